// ==== hw/fd_cfg_pkg.sv ====
/*
	Frame detector configuration definitions
	Register map, pattern storage sizes and pattern write types
*/

package fd_cfg_pkg;

	// Pattern storage geometry, per direction
	localparam int N_PATTERNS = 3;
	localparam int PAT_LEN = 16;
	localparam int PAT_IDX_W = $clog2(PAT_LEN);
	localparam int PAT_SEL_W = $clog2(N_PATTERNS);

	// Address space of the configuration write port
	localparam int ADDR_W = 12;
	localparam int DATA_W = 32;
	localparam logic [ADDR_W-1:0] ADDR_CFG = 12'h000;
	localparam logic [ADDR_W-1:0] ADDR_PAT_BASE = 12'h100;

	// One direction occupies 64 words of pattern space
	localparam int PAT_DIR_STRIDE = 64;
	localparam int PAT_DIR_BIT = $clog2(PAT_DIR_STRIDE);

	// Config register fields
	localparam int CFG_SRST_BIT = 0;
	localparam int CFG_EN_LSB = 1;

	typedef logic [N_PATTERNS-1:0] match_mask_t;

	typedef struct packed {
		logic valid;
		logic [ADDR_W-1:0] addr;
		logic [DATA_W-1:0] data;
	} cfg_write_t;

	// Low 17 bits of a pattern write word
	typedef struct packed {
		logic valid;
		logic [7:0] mask;
		logic [7:0] data;
	} pattern_entry_t;

	typedef struct packed {
		logic we;
		logic [PAT_SEL_W-1:0] pat;
		logic [PAT_IDX_W-1:0] idx;
		pattern_entry_t entry;
	} pattern_write_t;

endpackage

// ==== hw/fd_stream_pkg.sv ====
/*
	Frame detector stream definitions
	Beat and event types, timestamps, credit and FIFO sizing
*/

package fd_stream_pkg;

	// One byte of a MAC stream
	typedef struct packed {
		logic [7:0] data;
		logic user;
		logic last;
	} stream_beat_t;

	typedef logic [63:0] time_t;

	// Port the frame came in on
	typedef enum logic {
		DIR_A = 1'b0,
		DIR_B = 1'b1
	} dir_t;

	typedef struct packed {
		time_t timestamp;
		dir_t dir;
		fd_cfg_pkg::match_mask_t mask;
	} match_event_t;

	// Credit counters run from 0 up to TX_CREDITS
	localparam int TX_CREDITS = 4;
	localparam int CREDIT_W = $clog2(TX_CREDITS + 1);

	typedef logic [CREDIT_W-1:0] credit_t;

	localparam credit_t CREDIT_INIT = credit_t'(TX_CREDITS);

	// Both depths must be powers of two
	localparam int FRAME_FIFO_DEPTH = 64;
	localparam int EVENT_FIFO_DEPTH = 8;

endpackage

// ==== hw/frame_fifo.sv ====
/*
	Synchronous FIFO for any payload type
	Show-ahead read, flush empties it in one cycle
*/

`timescale 1ns/1ps

module frame_fifo #(
	parameter type payload_t = logic [7:0],
	parameter int DEPTH = 16
) (
	input logic clk,
	input logic rst,
	input logic flush,

	input logic push,
	input payload_t wdata,

	input logic pop,
	output payload_t rdata,

	output logic empty,
	output logic full
);
	payload_t mem [DEPTH];

	// Power-of-two depth, pointers wrap on their own
	logic [$clog2(DEPTH)-1:0] wr_ptr;
	logic [$clog2(DEPTH)-1:0] rd_ptr;
	logic [$clog2(DEPTH):0] count;

	logic do_push;
	logic do_pop;

	assign do_push = push && !full;
	assign do_pop = pop && !empty;

	// Count MSB alone means count == DEPTH
	assign empty = count == '0;
	assign full = count[$clog2(DEPTH)];

	assign rdata = mem[rd_ptr];

	// Storage
	always_ff @(posedge clk) begin
		if (do_push)
			mem[wr_ptr] <= wdata;
	end

	// Pointers and occupancy
	always_ff @(posedge clk) begin
		if (rst || flush) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			if (do_push)
				wr_ptr <= wr_ptr + 1'b1;
			if (do_pop)
				rd_ptr <= rd_ptr + 1'b1;
			case ({do_push, do_pop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end
endmodule

// ==== hw/frame_loop.sv ====
/*
	One forwarding direction
	Buffers received beats and sends them on under credit control
*/

`timescale 1ns/1ps

module frame_loop (
	input logic clk,
	input logic rst,
	input logic flush,

	input logic rx_valid,
	input fd_stream_pkg::stream_beat_t rx,

	output logic tx_valid,
	output fd_stream_pkg::stream_beat_t tx,
	input logic tx_credit
);
	logic fifo_empty;
	logic fifo_full;

	fd_stream_pkg::credit_t credits;

	// No back-pressure on rx, beats past a full FIFO are lost
	frame_fifo #(
		.payload_t(fd_stream_pkg::stream_beat_t),
		.DEPTH(fd_stream_pkg::FRAME_FIFO_DEPTH)
	) u_fifo (
		.clk(clk),
		.rst(rst),
		.flush(flush),
		.push(rx_valid && !fifo_full),
		.wdata(rx),
		.pop(tx_valid),
		.rdata(tx),
		.empty(fifo_empty),
		.full(fifo_full)
	);

	// Send head beat whenever a credit is held
	assign tx_valid = !fifo_empty && credits != '0 && !flush;

	// One credit spent per beat, one returned per pulse
	always_ff @(posedge clk) begin
		if (rst) begin
			credits <= fd_stream_pkg::CREDIT_INIT;
		end else begin
			case ({tx_valid, tx_credit})
				2'b10: credits <= credits - 1'b1;
				2'b01: credits <= credits + 1'b1;
				default: credits <= credits;
			endcase
		end
	end
endmodule

// ==== hw/pattern_matcher.sv ====
/*
	Pattern matcher for one receive direction
	Compares each frame byte against stored patterns, reports a mask at frame end
*/

`timescale 1ns/1ps

module pattern_matcher (
	input logic clk,
	input logic rst,
	input logic flush,

	input fd_cfg_pkg::pattern_write_t pat_wr,
	input fd_cfg_pkg::match_mask_t enable,

	input logic rx_valid,
	input fd_stream_pkg::stream_beat_t rx,

	output logic done,
	output fd_cfg_pkg::match_mask_t mask
);
	// Pattern storage, kept across resets
	fd_cfg_pkg::pattern_entry_t pat_mem [fd_cfg_pkg::N_PATTERNS][fd_cfg_pkg::PAT_LEN];

	// Byte offset in frame, saturates at PAT_LEN
	logic [fd_cfg_pkg::PAT_IDX_W:0] offs;

	// Patterns still matching so far
	fd_cfg_pkg::match_mask_t run;
	fd_cfg_pkg::match_mask_t run_cur;
	fd_cfg_pkg::match_mask_t run_nxt;

	logic past_end;

	assign past_end = offs[fd_cfg_pkg::PAT_IDX_W];

	// All patterns start live on the first byte
	assign run_cur = (offs == '0) ? '1 : run;

	always_ff @(posedge clk) begin
		if (pat_wr.we)
			pat_mem[pat_wr.pat][pat_wr.idx] <= pat_wr.entry;
	end

	// Byte compare and frame-end length check
	always_comb begin
		fd_cfg_pkg::pattern_entry_t ent;
		logic tail;

		run_nxt = run_cur;
		for (int p = 0; p < fd_cfg_pkg::N_PATTERNS; p++) begin
			ent = pat_mem[p][offs[fd_cfg_pkg::PAT_IDX_W-1:0]];

			// Only masked bits take part
			if (!past_end && ent.valid && ((rx.data ^ ent.data) & ent.mask) != '0)
				run_nxt[p] = 1'b0;

			// Valid entries after this byte
			tail = 1'b0;
			for (int i = 0; i < fd_cfg_pkg::PAT_LEN; i++) begin
				if (pat_mem[p][i].valid && i > int'(offs))
					tail = 1'b1;
			end

			// Frame too short for this pattern
			if (rx.last && tail)
				run_nxt[p] = 1'b0;
		end
	end

	// Frame progress
	always_ff @(posedge clk) begin
		if (rst || flush) begin
			offs <= '0;
			done <= 1'b0;
		end else begin
			done <= rx_valid && rx.last;
			if (rx_valid) begin
				if (rx.last)
					offs <= '0;
				else if (!past_end)
					offs <= offs + 1'b1;
			end
		end
	end

	// Running bits and result
	always_ff @(posedge clk) begin
		if (rx_valid) begin
			run <= run_nxt;
			if (rx.last)
				mask <= run_nxt & enable;
		end
	end
endmodule

// ==== hw/fd_control.sv ====
/*
	Frame detector control
	Config register, pattern write routing and the timestamped event queue
*/

`timescale 1ns/1ps

module fd_control (
	input logic clk,
	input logic rst,

	input fd_cfg_pkg::cfg_write_t cfg,
	input fd_stream_pkg::time_t current_time,

	output fd_cfg_pkg::pattern_write_t pat_wr_a,
	output fd_cfg_pkg::pattern_write_t pat_wr_b,
	output fd_cfg_pkg::match_mask_t enable_a,
	output fd_cfg_pkg::match_mask_t enable_b,
	output logic flush,

	input logic rx_a_last,
	input logic rx_b_last,

	input logic done_a,
	input logic done_b,
	input fd_cfg_pkg::match_mask_t mask_a,
	input fd_cfg_pkg::match_mask_t mask_b,

	output logic event_valid,
	output fd_stream_pkg::match_event_t event_out,
	input logic event_credit
);
	logic srst;
	logic [2*fd_cfg_pkg::N_PATTERNS-1:0] en;

	logic [fd_cfg_pkg::ADDR_W-1:0] pat_offs;
	logic pat_hit;
	fd_cfg_pkg::pattern_write_t pat_wr;

	fd_stream_pkg::time_t ts_a;
	fd_stream_pkg::time_t ts_b;

	fd_stream_pkg::match_event_t ev_a;
	fd_stream_pkg::match_event_t ev_b;
	fd_stream_pkg::match_event_t pend_ev;
	fd_stream_pkg::match_event_t push_ev;
	logic push_a;
	logic push_b;
	logic pend_valid;

	logic ev_empty;
	logic ev_full;
	fd_stream_pkg::credit_t credits;

	// Config register, soft reset also drops enables
	always_ff @(posedge clk) begin
		if (rst) begin
			srst <= 1'b0;
			en <= '0;
		end else if (cfg.valid && cfg.addr == fd_cfg_pkg::ADDR_CFG) begin
			srst <= cfg.data[fd_cfg_pkg::CFG_SRST_BIT];
			if (cfg.data[fd_cfg_pkg::CFG_SRST_BIT])
				en <= '0;
			else
				en <= cfg.data[fd_cfg_pkg::CFG_EN_LSB +: 2*fd_cfg_pkg::N_PATTERNS];
		end
	end

	assign flush = srst;
	assign enable_a = en[fd_cfg_pkg::N_PATTERNS-1:0];
	assign enable_b = en[2*fd_cfg_pkg::N_PATTERNS-1:fd_cfg_pkg::N_PATTERNS];

	// Pattern space: dir x 64 + pattern x 16 + entry
	assign pat_offs = cfg.addr - fd_cfg_pkg::ADDR_PAT_BASE;
	assign pat_hit = cfg.valid && cfg.addr >= fd_cfg_pkg::ADDR_PAT_BASE
		&& pat_offs[fd_cfg_pkg::ADDR_W-1:fd_cfg_pkg::PAT_DIR_BIT+1] == '0
		&& int'(pat_offs[fd_cfg_pkg::PAT_IDX_W +: fd_cfg_pkg::PAT_SEL_W])
			< fd_cfg_pkg::N_PATTERNS;

	assign pat_wr.pat = pat_offs[fd_cfg_pkg::PAT_IDX_W +: fd_cfg_pkg::PAT_SEL_W];
	assign pat_wr.idx = pat_offs[fd_cfg_pkg::PAT_IDX_W-1:0];
	assign pat_wr.entry = fd_cfg_pkg::pattern_entry_t'(cfg.data[$bits(fd_cfg_pkg::pattern_entry_t)-1:0]);
	assign pat_wr.we = pat_hit;

	// Strobe only to the addressed direction
	always_comb begin
		pat_wr_a = pat_wr;
		pat_wr_b = pat_wr;
		pat_wr_a.we = pat_wr.we && !pat_offs[fd_cfg_pkg::PAT_DIR_BIT];
		pat_wr_b.we = pat_wr.we && pat_offs[fd_cfg_pkg::PAT_DIR_BIT];
	end

	// Time of last beat, a cycle ahead of done
	always_ff @(posedge clk) begin
		if (rx_a_last)
			ts_a <= current_time;
		if (rx_b_last)
			ts_b <= current_time;
	end

	assign ev_a = '{timestamp: ts_a, dir: fd_stream_pkg::DIR_A, mask: mask_a};
	assign ev_b = '{timestamp: ts_b, dir: fd_stream_pkg::DIR_B, mask: mask_b};

	assign push_a = done_a && mask_a != '0 && !flush;
	assign push_b = done_b && mask_b != '0 && !flush;

	// A wins a tie, B waits one cycle in pend_ev
	assign push_ev = pend_valid ? pend_ev : (push_a ? ev_a : ev_b);

	always_ff @(posedge clk) begin
		if (rst || flush)
			pend_valid <= 1'b0;
		else
			pend_valid <= push_a && push_b;
		if (push_a && push_b)
			pend_ev <= ev_b;
	end

	frame_fifo #(
		.payload_t(fd_stream_pkg::match_event_t),
		.DEPTH(fd_stream_pkg::EVENT_FIFO_DEPTH)
	) u_event_fifo (
		.clk(clk),
		.rst(rst),
		.flush(flush),
		.push((pend_valid || push_a || push_b) && !ev_full),
		.wdata(push_ev),
		.pop(event_valid),
		.rdata(event_out),
		.empty(ev_empty),
		.full(ev_full)
	);

	assign event_valid = !ev_empty && credits != '0 && !flush;

	// Event output credits
	always_ff @(posedge clk) begin
		if (rst) begin
			credits <= fd_stream_pkg::CREDIT_INIT;
		end else begin
			case ({event_valid, event_credit})
				2'b10: credits <= credits - 1'b1;
				2'b01: credits <= credits + 1'b1;
				default: credits <= credits;
			endcase
		end
	end
endmodule

// ==== hw/eth_frame_detector.sv ====
/*
	Two-port Ethernet frame detector
	Forwards A to B and B to A, and reports timestamped pattern matches
*/

`timescale 1ns/1ps

module eth_frame_detector (
	input logic clk,
	input logic rst,

	// Configuration and time base
	input fd_cfg_pkg::cfg_write_t cfg,
	input fd_stream_pkg::time_t current_time,

	// Receive streams, no back-pressure
	input logic rx_a_valid,
	input fd_stream_pkg::stream_beat_t rx_a,
	input logic rx_b_valid,
	input fd_stream_pkg::stream_beat_t rx_b,

	// Transmit streams, credit based
	output logic tx_a_valid,
	output fd_stream_pkg::stream_beat_t tx_a,
	input logic tx_a_credit,
	output logic tx_b_valid,
	output fd_stream_pkg::stream_beat_t tx_b,
	input logic tx_b_credit,

	// Match events
	output logic event_valid,
	output fd_stream_pkg::match_event_t event_out,
	input logic event_credit
);
	logic flush;

	fd_cfg_pkg::pattern_write_t pat_wr_a;
	fd_cfg_pkg::pattern_write_t pat_wr_b;
	fd_cfg_pkg::match_mask_t enable_a;
	fd_cfg_pkg::match_mask_t enable_b;

	logic done_a;
	logic done_b;
	fd_cfg_pkg::match_mask_t mask_a;
	fd_cfg_pkg::match_mask_t mask_b;

	fd_control u_control (
		.clk(clk),
		.rst(rst),
		.cfg(cfg),
		.current_time(current_time),
		.pat_wr_a(pat_wr_a),
		.pat_wr_b(pat_wr_b),
		.enable_a(enable_a),
		.enable_b(enable_b),
		.flush(flush),
		.rx_a_last(rx_a_valid && rx_a.last),
		.rx_b_last(rx_b_valid && rx_b.last),
		.done_a(done_a),
		.done_b(done_b),
		.mask_a(mask_a),
		.mask_b(mask_b),
		.event_valid(event_valid),
		.event_out(event_out),
		.event_credit(event_credit)
	);

	// B received, sent out on A
	frame_loop u_loop_b2a (
		.clk(clk),
		.rst(rst),
		.flush(flush),
		.rx_valid(rx_b_valid),
		.rx(rx_b),
		.tx_valid(tx_a_valid),
		.tx(tx_a),
		.tx_credit(tx_a_credit)
	);

	// A received, sent out on B
	frame_loop u_loop_a2b (
		.clk(clk),
		.rst(rst),
		.flush(flush),
		.rx_valid(rx_a_valid),
		.rx(rx_a),
		.tx_valid(tx_b_valid),
		.tx(tx_b),
		.tx_credit(tx_b_credit)
	);

	// Matchers watch their own receive port
	pattern_matcher u_match_a (
		.clk(clk),
		.rst(rst),
		.flush(flush),
		.pat_wr(pat_wr_a),
		.enable(enable_a),
		.rx_valid(rx_a_valid),
		.rx(rx_a),
		.done(done_a),
		.mask(mask_a)
	);

	pattern_matcher u_match_b (
		.clk(clk),
		.rst(rst),
		.flush(flush),
		.pat_wr(pat_wr_b),
		.enable(enable_b),
		.rx_valid(rx_b_valid),
		.rx(rx_b),
		.done(done_b),
		.mask(mask_b)
	);
endmodule

// ==== bench/tb_eth_frame_detector.sv ====
/*
	Testbench for the two-port Ethernet frame detector
	Random frames in both directions, reference pattern match, credit checks
*/

`timescale 1ns/1ps

module tb_eth_frame_detector;

	logic clk;
	logic rst;
	fd_cfg_pkg::cfg_write_t cfg;
	fd_stream_pkg::time_t current_time;
	logic rx_a_valid;
	fd_stream_pkg::stream_beat_t rx_a;
	logic rx_b_valid;
	fd_stream_pkg::stream_beat_t rx_b;
	logic tx_a_valid;
	fd_stream_pkg::stream_beat_t tx_a;
	logic tx_a_credit;
	logic tx_b_valid;
	fd_stream_pkg::stream_beat_t tx_b;
	logic tx_b_credit;
	logic event_valid;
	fd_stream_pkg::match_event_t event_out;
	logic event_credit;

	// Copy of patterns and enables, index 0 is port A
	fd_cfg_pkg::pattern_entry_t pat [2][fd_cfg_pkg::N_PATTERNS][fd_cfg_pkg::PAT_LEN];
	fd_cfg_pkg::match_mask_t en [2];

	// Frame in flight on each port
	logic [7:0] frame_data [2][24];
	int frame_len [2];

	// Expected traffic, tx_a carries what B received
	fd_stream_pkg::stream_beat_t exp_a [$];
	fd_stream_pkg::stream_beat_t exp_b [$];
	fd_stream_pkg::match_event_t exp_ev [$];

	// Credit bookkeeping for tx_a, tx_b and events
	int sent [3];
	int returned [3];
	int owed [3];
	string out_name [3] = '{"tx_a", "tx_b", "event_out"};
	logic hold;

	int seed = 96;
	int beats_sent;
	int cycle_count;
	int beat_errors;
	int event_errors;
	int other_errors;

	eth_frame_detector DUT (
		.clk(clk),
		.rst(rst),
		.cfg(cfg),
		.current_time(current_time),
		.rx_a_valid(rx_a_valid),
		.rx_a(rx_a),
		.rx_b_valid(rx_b_valid),
		.rx_b(rx_b),
		.tx_a_valid(tx_a_valid),
		.tx_a(tx_a),
		.tx_a_credit(tx_a_credit),
		.tx_b_valid(tx_b_valid),
		.tx_b(tx_b),
		.tx_b_credit(tx_b_credit),
		.event_valid(event_valid),
		.event_out(event_out),
		.event_credit(event_credit)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	// Time base counts cycles
	always @(posedge clk)
		current_time <= current_time + 1;

	task check_beat(input string name, input fd_stream_pkg::stream_beat_t got,
			input fd_stream_pkg::stream_beat_t want);
		if (got !== want) begin
			beat_errors++;
			$display("[ERROR] %s: got data %h user %h last %h, expected data %h user %h last %h",
				name, got.data, got.user, got.last, want.data, want.user, want.last);
		end
	endtask

	task check_event(input fd_stream_pkg::match_event_t got,
			input fd_stream_pkg::match_event_t want);
		if (got !== want) begin
			event_errors++;
			$display("[ERROR] event_out: got time %h dir %h mask %h, expected time %h dir %h mask %h",
				got.timestamp, got.dir, got.mask, want.timestamp, want.dir, want.mask);
		end
	endtask

	// Compare outputs, check credit use, return credits at random
	always @(posedge clk) begin
		logic [2:0] vld;
		logic [2:0] crd;
		logic [2:0] pulse;
		int r;

		vld = {event_valid, tx_b_valid, tx_a_valid};
		crd = {event_credit, tx_b_credit, tx_a_credit};
		pulse = '0;
		if (!rst) begin
			for (int k = 0; k < 3; k++) begin
				if (vld[k]) begin
					sent[k]++;
					owed[k]++;
					if (sent[k] > fd_stream_pkg::TX_CREDITS + returned[k]) begin
						other_errors++;
						$display("Credit overrun on %s: %0d sent with %0d credits returned",
							out_name[k], sent[k], returned[k]);
					end
				end
				if (crd[k])
					returned[k]++;
				r = $random(seed);
				if (owed[k] > 0 && !hold && r[2:0] != 3'b000) begin
					pulse[k] = 1'b1;
					owed[k]--;
				end
			end
			if (tx_a_valid) begin
				if (exp_a.size() == 0) begin
					other_errors++;
					$display("Unexpected beat on tx_a");
				end else
					check_beat("tx_a", tx_a, exp_a.pop_front());
			end
			if (tx_b_valid) begin
				if (exp_b.size() == 0) begin
					other_errors++;
					$display("Unexpected beat on tx_b");
				end else
					check_beat("tx_b", tx_b, exp_b.pop_front());
			end
			if (event_valid) begin
				if (exp_ev.size() == 0) begin
					other_errors++;
					$display("Unexpected match event");
				end else
					check_event(event_out, exp_ev.pop_front());
			end
		end
		tx_a_credit <= pulse[0];
		tx_b_credit <= pulse[1];
		event_credit <= pulse[2];
	end

	task write_cfg(input logic [fd_cfg_pkg::ADDR_W-1:0] addr, input logic [31:0] data);
		@(posedge clk);
		cfg <= '{valid: 1'b1, addr: addr, data: data};
		@(posedge clk);
		cfg <= '0;
	endtask

	// Enable bits sit above the soft reset bit, A then B
	task set_enables(input fd_cfg_pkg::match_mask_t ena, input fd_cfg_pkg::match_mask_t enb);
		en[0] = ena;
		en[1] = enb;
		write_cfg(fd_cfg_pkg::ADDR_CFG, {25'b0, enb, ena, 1'b0});
	endtask

	// Pattern p has its valid entries among the first 4 + 4p
	task load_patterns();
		int r;
		fd_cfg_pkg::pattern_entry_t e;

		for (int d = 0; d < 2; d++) begin
			for (int p = 0; p < fd_cfg_pkg::N_PATTERNS; p++) begin
				for (int i = 0; i < fd_cfg_pkg::PAT_LEN; i++) begin
					r = $random(seed);
					e.valid = i < 4 + 4 * p && r[1:0] != 2'b00;
					e.mask = r[15:8];
					e.data = r[23:16];
					pat[d][p][i] = e;
					write_cfg(12'(fd_cfg_pkg::ADDR_PAT_BASE + d * 64 + p * 16 + i), {15'b0, e});
				end
			end
		end
	endtask

	// Expected mask of the frame on port d
	function fd_cfg_pkg::match_mask_t ref_mask(input int d);
		fd_cfg_pkg::match_mask_t m;
		fd_cfg_pkg::pattern_entry_t e;

		m = '0;
		for (int p = 0; p < fd_cfg_pkg::N_PATTERNS; p++) begin
			m[p] = 1'b1;
			for (int i = 0; i < fd_cfg_pkg::PAT_LEN; i++) begin
				e = pat[d][p][i];
				// Entry past the frame end, or a masked bit differs
				if (e.valid && (i >= frame_len[d]
						|| ((frame_data[d][i] ^ e.data) & e.mask) != 8'h00))
					m[p] = 1'b0;
			end
		end
		return m & en[d];
	endfunction

	// Half the frames are shaped after one pattern, don't-care bits random
	task build_frame(input int d);
		int r;
		int p;
		fd_cfg_pkg::pattern_entry_t e;

		frame_len[d] = 2 + int'({$random(seed)} % 23);
		p = int'({$random(seed)} % fd_cfg_pkg::N_PATTERNS);
		r = $random(seed);
		for (int i = 0; i < 24; i++) begin
			frame_data[d][i] = 8'($random(seed));
			if (r[0] && i < fd_cfg_pkg::PAT_LEN) begin
				e = pat[d][p][i];
				if (e.valid)
					frame_data[d][i] = (e.data & e.mask) | (frame_data[d][i] & ~e.mask);
			end
		end
	endtask

	// Both ports start together, equal lengths end in the same cycle
	task send_pair();
		int n;
		int r;
		fd_stream_pkg::stream_beat_t b;
		fd_stream_pkg::match_event_t ev;

		n = frame_len[0] > frame_len[1] ? frame_len[0] : frame_len[1];
		for (int i = 0; i < n; i++) begin
			@(posedge clk);
			for (int d = 0; d < 2; d++) begin
				r = $random(seed);
				b.data = frame_data[d][i];
				b.user = r[0];
				b.last = i == frame_len[d] - 1;
				if (i >= frame_len[d]) begin
					if (d == 0)
						rx_a_valid <= 1'b0;
					else
						rx_b_valid <= 1'b0;
				end else begin
					beats_sent++;
					if (d == 0) begin
						rx_a_valid <= 1'b1;
						rx_a <= b;
						exp_b.push_back(b);
					end else begin
						rx_b_valid <= 1'b1;
						rx_b <= b;
						exp_a.push_back(b);
					end
					// DUT samples the next time value with this beat
					if (b.last && ref_mask(d) != '0) begin
						ev.timestamp = current_time + 1;
						ev.dir = (d == 0) ? fd_stream_pkg::DIR_A : fd_stream_pkg::DIR_B;
						ev.mask = ref_mask(d);
						exp_ev.push_back(ev);
					end
				end
			end
		end
		@(posedge clk);
		rx_a_valid <= 1'b0;
		rx_b_valid <= 1'b0;
	endtask

	task run_rounds(input int n);
		for (int k = 0; k < n; k++) begin
			build_frame(0);
			build_frame(1);
			send_pair();
		end
	endtask

	task drain();
		while (exp_a.size() + exp_b.size() + exp_ev.size() != 0)
			@(posedge clk);
	endtask

	// Limit grows with the traffic sent
	initial begin
		cycle_count = 0;
		while (cycle_count < 2000 + 40 * beats_sent) begin
			@(posedge clk);
			cycle_count++;
		end
		$display("Timeout: the run did not finish within %0d cycles", cycle_count);
		$display("Test failed");
		$finish;
	end

	initial begin
		rst = 1'b1;
		cfg = '0;
		current_time = '0;
		rx_a_valid = 1'b0;
		rx_a = '0;
		rx_b_valid = 1'b0;
		rx_b = '0;
		tx_a_credit = 1'b0;
		tx_b_credit = 1'b0;
		event_credit = 1'b0;
		hold = 1'b0;
		repeat (4) @(posedge clk);
		rst <= 1'b0;
		load_patterns();

		// All patterns enabled
		set_enables(3'b111, 3'b111);
		run_rounds(30);
		drain();

		// Some patterns disabled
		set_enables(3'b101, 3'b010);
		run_rounds(20);
		drain();

		// Credits withheld, then returned
		hold <= 1'b1;
		run_rounds(2);
		repeat (40) @(posedge clk);
		hold <= 1'b0;
		drain();

		// Soft reset with beats and events still queued
		set_enables(3'b111, 3'b111);
		hold <= 1'b1;
		run_rounds(2);
		repeat (10) @(posedge clk);
		write_cfg(fd_cfg_pkg::ADDR_CFG, 32'h1);
		repeat (3) @(posedge clk);
		exp_a.delete();
		exp_b.delete();
		exp_ev.delete();
		write_cfg(fd_cfg_pkg::ADDR_CFG, 32'h0);
		en[0] = '0;
		en[1] = '0;
		hold <= 1'b0;
		run_rounds(6);
		drain();

		// Patterns survive, enables written again
		set_enables(3'b111, 3'b111);
		run_rounds(10);
		drain();
		repeat (30) @(posedge clk);

		$display("Errors: %0d beat, %0d event, %0d other", beat_errors, event_errors,
			other_errors);
		if (beat_errors + event_errors + other_errors == 0)
			$display("Test passed");
		else
			$display("Test failed");
		$finish;
	end
endmodule

// ==== all.f ====
hw/fd_cfg_pkg.sv
hw/fd_stream_pkg.sv
hw/frame_fifo.sv
hw/frame_loop.sv
hw/pattern_matcher.sv
hw/fd_control.sv
hw/eth_frame_detector.sv
bench/tb_eth_frame_detector.sv

// ==== Makefile ====
TOP = tb_eth_frame_detector
LOG = sim.log

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing -f all.f --top-module $(TOP) -Mdir obj_dir -o sim

run: build
	./obj_dir/sim | tee $(LOG)
	grep -q "^Test passed$$" $(LOG)

lint:
	verilator --lint-only --timing -Wall -f all.f --top-module eth_frame_detector

clean:
	rm -rf obj_dir $(LOG)
